/* source/csrBank_params.svh */
// *********************************************************************
// CSR bank configuration: addresses, identity values, pins and timer
// *********************************************************************
`ifndef CSRBANK_PARAMS_SVH
`define CSRBANK_PARAMS_SVH

`define CSR_MISA      12'h301
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14
`define CSR_KHZ       12'hFC0
`define CSR_LEDS      12'hBC1
`define CSR_TIMER     12'hBC2

// Counter aliases, machine and user views
`define CSR_MCYCLE    12'hB00
`define CSR_CYCLE     12'hC00
`define CSR_TIME      12'hC01
`define CSR_MCYCLEH   12'hB80
`define CSR_CYCLEH    12'hC80
`define CSR_TIMEH     12'hC81
`define CSR_MINSTRET  12'hB02
`define CSR_INSTRET   12'hC02
`define CSR_MINSTRETH 12'hB82
`define CSR_INSTRETH  12'hC82

`define ISA_VALUE     32'h4000_0100 // RV32I
`define VENDOR_VALUE  32'h0000_0000
`define ARCH_VALUE    32'h0000_0025
`define IMP_VALUE     32'h0001_0000
`define HART_VALUE    32'h0000_0000
`define CLOCK_KHZ     32'd100000

`define OUT_PINS      4
`define PINS_RESET    1 // LED 0 lit after reset
`define TIMER_WIDTH   32

`endif

/* source/csrPkg.sv */
// *********************************************************************
// Shared types of the CSR bank: data, address, modify code and pins
// *********************************************************************
`default_nettype none
`include "csrBank_params.svh"

package csrPkg;

    typedef logic [31:0] csrDataT;
    typedef logic [11:0] csrAddrT;

    // Modify code presented by the core in E
    typedef enum logic [2:0] {
        opNone  = 3'd0,
        opWrite = 3'd1,
        opSet   = 3'd2,
        opClear = 3'd3
    } csrOpT;

    typedef logic [`OUT_PINS-1:0] pinsT;

endpackage

`default_nettype wire

/* source/csrIds.sv */
// *********************************************************************
// Read-only machine identity registers and clock frequency in kHz
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "csrBank_params.svh"

module csrIds
    import csrPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    output csrDataT rdata,
    output logic    valid
);

    logic enIsa;
    logic enVendor;
    logic enArch;
    logic enImp;
    logic enHart;
    logic enKhz;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            enIsa    <= 1'b0;
            enVendor <= 1'b0;
            enArch   <= 1'b0;
            enImp    <= 1'b0;
            enHart   <= 1'b0;
            enKhz    <= 1'b0;
            valid    <= 1'b0;
            rdata    <= '0;
        end else begin
            // Decode in D
            enIsa    <= (addr == `CSR_MISA);
            enVendor <= (addr == `CSR_MVENDORID);
            enArch   <= (addr == `CSR_MARCHID);
            enImp    <= (addr == `CSR_MIMPID);
            enHart   <= (addr == `CSR_MHARTID);
            enKhz    <= (addr == `CSR_KHZ);

            valid <= enIsa | enVendor | enArch | enImp | enHart | enKhz;
            rdata <= (enIsa    ? `ISA_VALUE    : '0)
                   | (enVendor ? `VENDOR_VALUE : '0)
                   | (enArch   ? `ARCH_VALUE   : '0)
                   | (enImp    ? `IMP_VALUE    : '0)
                   | (enHart   ? `HART_VALUE   : '0)
                   | (enKhz    ? `CLOCK_KHZ    : '0);
        end
    end

endmodule

`default_nettype wire

/* source/csrCounters.sv */
// *********************************************************************
// 64-bit cycle and retired-instruction counters, read as 32-bit halves
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "csrBank_params.svh"

module csrCounters
    import csrPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    input  logic    retired,
    output csrDataT rdata,
    output logic    valid
);

    logic enCycleLo;
    logic enCycleHi;
    logic enRetLo;
    logic enRetHi;

    // Low halves carry one extra bit for the delayed carry
    logic [32:0] cycleLo;
    csrDataT     cycleHi;
    logic [32:0] retLo;
    csrDataT     retHi;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            enCycleLo <= 1'b0;
            enCycleHi <= 1'b0;
            enRetLo   <= 1'b0;
            enRetHi   <= 1'b0;
            cycleLo   <= '0;
            cycleHi   <= '0;
            retLo     <= '0;
            retHi     <= '0;
            valid     <= 1'b0;
            rdata     <= '0;
        end else begin
            enCycleLo <= (addr == `CSR_MCYCLE) | (addr == `CSR_CYCLE) | (addr == `CSR_TIME);
            enCycleHi <= (addr == `CSR_MCYCLEH) | (addr == `CSR_CYCLEH)
                       | (addr == `CSR_TIMEH);
            enRetLo   <= (addr == `CSR_MINSTRET) | (addr == `CSR_INSTRET);
            enRetHi   <= (addr == `CSR_MINSTRETH) | (addr == `CSR_INSTRETH);

            valid <= enCycleLo | enCycleHi | enRetLo | enRetHi;
            rdata <= (enCycleLo ? cycleLo[31:0] : '0)
                   | (enCycleHi ? cycleHi       : '0)
                   | (enRetLo   ? retLo[31:0]   : '0)
                   | (enRetHi   ? retHi         : '0);

            // Carry lands in the high half one cycle later
            cycleLo <= {1'b0, cycleLo[31:0]} + 33'd1;
            cycleHi <= cycleHi + {31'b0, cycleLo[32]};
            retLo   <= {1'b0, retLo[31:0]} + {32'b0, retired};
            retHi   <= retHi + {31'b0, retLo[32]};
        end
    end

    // Alias decode never selects two halves at once
    assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({enCycleLo, enCycleHi, enRetLo, enRetHi}));

endmodule

`default_nettype wire

/* source/csrPinsOut.sv */
// *********************************************************************
// LED output register with write, set and clear access
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "csrBank_params.svh"

module csrPinsOut
    import csrPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    input  csrOpT   modify,
    input  csrDataT wdata,
    output pinsT    pins,
    output csrDataT rdata,
    output logic    valid
);

    logic enPins;
    pinsT wbits;

    assign wbits = wdata[`OUT_PINS-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            enPins <= 1'b0;
            pins   <= pinsT'(`PINS_RESET);
            valid  <= 1'b0;
            rdata  <= '0;
        end else begin
            enPins <= (addr == `CSR_LEDS);

            // Read returns the value before this access's write
            valid <= enPins;
            rdata <= enPins ? {{(32-`OUT_PINS){1'b0}}, pins} : '0;

            if (enPins) begin
                case (modify)
                    opWrite: pins <= wbits;
                    opSet:   pins <= pins | wbits;
                    opClear: pins <= pins & ~wbits;
                    default: ;            // None or undefined code
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/csrTimer.sv */
// *********************************************************************
// One-shot relative timer that counts down and raises an interrupt
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "csrBank_params.svh"

module csrTimer
    import csrPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    input  csrOpT   modify,
    input  csrDataT wdata,
    output logic    irq
);

    logic                    enTimer;
    logic                    armed;
    logic [`TIMER_WIDTH-1:0] count;
    logic                    countZero;

    assign countZero = (count == '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            enTimer <= 1'b0;
            armed   <= 1'b0;
            count   <= '0;
            irq     <= 1'b0;
        end else begin
            enTimer <= (addr == `CSR_TIMER);

            // Raised one edge after the count reaches zero
            irq <= armed & countZero;

            if (enTimer && modify == opWrite) begin
                count <= wdata[`TIMER_WIDTH-1:0]; // Load beats decrement
                armed <= 1'b1;
            end else begin
                if (!countZero) begin
                    count <= count - `TIMER_WIDTH'(1);
                end
                if (enTimer && modify == opClear) begin
                    armed <= 1'b0;    // Any clear value disarms
                end
            end
        end
    end

    // A clear drops irq by the second edge after its E edge
    assert property (@(posedge clk) disable iff (!rstn)
        $past(enTimer && modify == opClear, 2) |-> !irq);

endmodule

`default_nettype wire

/* source/csrBank.sv */
// *********************************************************************
// CSR bank top: identity, counters, LEDs and timer on one CSR bus
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none

module csrBank
    import csrPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    input  csrOpT   modify,
    input  csrDataT wdata,
    input  logic    retired,
    output csrDataT rdata,
    output logic    valid,
    output pinsT    leds,
    output logic    irqTimer
);

    csrDataT idsRdata;
    logic    idsValid;
    csrDataT cntRdata;
    logic    cntValid;
    csrDataT pinsRdata;
    logic    pinsValid;

    csrIds ids (
        .clk   (clk),
        .rstn  (rstn),
        .addr  (addr),
        .rdata (idsRdata),
        .valid (idsValid)
    );

    csrCounters counters (
        .clk     (clk),
        .rstn    (rstn),
        .addr    (addr),
        .retired (retired),
        .rdata   (cntRdata),
        .valid   (cntValid)
    );

    csrPinsOut pinsOut (
        .clk    (clk),
        .rstn   (rstn),
        .addr   (addr),
        .modify (modify),
        .wdata  (wdata),
        .pins   (leds),
        .rdata  (pinsRdata),
        .valid  (pinsValid)
    );

    // Write-only block, no read path
    csrTimer timer (
        .clk    (clk),
        .rstn   (rstn),
        .addr   (addr),
        .modify (modify),
        .wdata  (wdata),
        .irq    (irqTimer)
    );

    // Idle blocks drive zeros, so a plain OR merges them
    assign rdata = idsRdata | cntRdata | pinsRdata;
    assign valid = idsValid | cntValid | pinsValid;

    // Address maps of the blocks must not overlap
    assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({idsValid, cntValid, pinsValid}));

endmodule

`default_nettype wire

/* verif/csrBankTb.sv */
// *********************************************************************
// Directed testbench for the CSR bank: identity, counters, LEDs, timer
// *********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "csrBank_params.svh"

module csrBankTb
    import csrPkg::*;
;

    localparam csrAddrT idleAddr  = 12'h000;  // Unmapped, parks the bus
    localparam csrAddrT emptyAddr = 12'h7C0;

    logic    clk = 1'b0;
    logic    rstn;
    csrAddrT addr;
    csrOpT   modify;
    csrDataT wdata;
    logic    retired;
    csrDataT rdata;
    logic    valid;
    pinsT    leds;
    logic    irqTimer;

    csrBank DUT (
        .clk      (clk),
        .rstn     (rstn),
        .addr     (addr),
        .modify   (modify),
        .wdata    (wdata),
        .retired  (retired),
        .rdata    (rdata),
        .valid    (valid),
        .leds     (leds),
        .irqTimer (irqTimer)
    );

    always #5 clk = ~clk;

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkData(input string name, input csrDataT got, input csrDataT exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkPins(input string name, input pinsT got, input pinsT exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    // Address in D, modify and wdata in E, sample in M
    task automatic csrAccess(input csrAddrT a, input csrOpT op, input csrDataT d,
                             output csrDataT rd, output logic vd);
        addr = a;
        @(posedge clk);
        #1;
        addr   = idleAddr;
        modify = op;
        wdata  = d;
        @(posedge clk);
        #1;
        rd     = rdata;
        vd     = valid;
        modify = opNone;
        wdata  = '0;
    endtask

    task automatic readCheck(input string name, input csrAddrT a, input csrDataT exp);
        csrDataT rd;
        logic    vd;
        csrAccess(a, opNone, '0, rd, vd);
        checkBit({name, " valid"}, vd, 1'b1);
        checkData(name, rd, exp);
    endtask

    // Counts edges until irq reaches the level
    task automatic waitIrq(input logic level, input int limit, output int edges);
        edges = 0;
        while (irqTimer !== level) begin
            if (edges >= limit) begin
                $display("Timeout: irq did not reach %b within %0d cycles", level, limit);
                abortRun();
            end else begin
                @(posedge clk);
                #1;
                edges++;
            end
        end
    endtask

    task automatic testIds();
        csrDataT rd;
        logic    vd;
        readCheck("misa", `CSR_MISA, `ISA_VALUE);
        readCheck("mvendorid", `CSR_MVENDORID, `VENDOR_VALUE);
        readCheck("marchid", `CSR_MARCHID, `ARCH_VALUE);
        readCheck("mimpid", `CSR_MIMPID, `IMP_VALUE);
        readCheck("mhartid", `CSR_MHARTID, `HART_VALUE);
        readCheck("khz", `CSR_KHZ, `CLOCK_KHZ);
        csrAccess(emptyAddr, opNone, '0, rd, vd);
        checkBit("unmapped valid", vd, 1'b0);
        checkData("unmapped rdata", rd, '0);
    endtask

    task automatic testCycles();
        csrDataT first;
        csrDataT second;
        logic    vd;
        int      k;
        k = 2 + $urandom % 20;
        csrAccess(`CSR_CYCLE, opNone, '0, first, vd);
        repeat (k - 2) begin
            @(posedge clk);
            #1;
        end
        csrAccess(`CSR_MCYCLE, opNone, '0, second, vd);  // Issued k cycles later
        checkData("cycle delta", second - first, csrDataT'(k));
        readCheck("mcycleh", `CSR_MCYCLEH, '0);
        readCheck("cycleh", `CSR_CYCLEH, '0);
        readCheck("timeh", `CSR_TIMEH, '0);
    endtask

    task automatic testRetired();
        int r;
        int gap;
        r = 1 + $urandom % 30;
        for (int i = 0; i < r; i++) begin
            retired = 1'b1;
            @(posedge clk);
            #1;
            retired = 1'b0;
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        readCheck("minstret", `CSR_MINSTRET, csrDataT'(r));
        readCheck("instret", `CSR_INSTRET, csrDataT'(r));
        readCheck("minstreth", `CSR_MINSTRETH, '0);
        readCheck("instreth", `CSR_INSTRETH, '0);
    endtask

    task automatic testLeds();
        pinsT    exp;
        csrDataT w;
        csrDataT rd;
        logic    vd;
        exp = pinsT'(`PINS_RESET);
        checkPins("leds after reset", leds, exp);

        w = $urandom;                                   // Upper bits must be ignored
        csrAccess(`CSR_LEDS, opWrite, w, rd, vd);
        checkData("leds old value", rd, csrDataT'(exp));
        exp = w[`OUT_PINS-1:0];
        checkPins("leds after write", leds, exp);

        w = $urandom;
        csrAccess(`CSR_LEDS, opSet, w, rd, vd);
        exp = exp | w[`OUT_PINS-1:0];
        checkPins("leds after set", leds, exp);

        w = $urandom;
        csrAccess(`CSR_LEDS, opClear, w, rd, vd);
        exp = exp & ~w[`OUT_PINS-1:0];
        checkPins("leds after clear", leds, exp);

        readCheck("leds read", `CSR_LEDS, csrDataT'(exp));
        checkData("leds read vs pins", rdata, csrDataT'(leds));
    endtask

    task automatic testTimer();
        csrDataT rd;
        logic    vd;
        int      n;
        int      edges;
        for (int round = 0; round < 2; round++) begin
            n = 1 + $urandom % 40;
            csrAccess(`CSR_TIMER, opWrite, csrDataT'(n), rd, vd);
            checkBit("timer valid", vd, 1'b0);
            checkData("timer rdata", rd, '0);
            waitIrq(1'b1, n + 5, edges);
            checkData("irq delay", csrDataT'(edges), csrDataT'(n + 1));
            repeat (5) begin
                @(posedge clk);
                #1;
                checkBit("irq held", irqTimer, 1'b1);
            end
            csrAccess(`CSR_TIMER, opClear, $urandom, rd, vd);
            waitIrq(1'b0, 2, edges);
        end
    endtask

    initial begin
        rstn    = 1'b0;
        addr    = idleAddr;
        modify  = opNone;
        wdata   = '0;
        retired = 1'b0;
        void'($urandom(32'h1354_0f4c));

        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        checkBit("valid after reset", valid, 1'b0);
        checkBit("irq after reset", irqTimer, 1'b0);

        testLeds();
        testIds();
        testCycles();
        testRetired();
        testTimer();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/csrPkg.sv
source/csrIds.sv
source/csrCounters.sv
source/csrPinsOut.sv
source/csrTimer.sv
source/csrBank.sv
verif/csrBankTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CSR bank testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module csrBankTb -o csrBankSim \
    && ./obj_dir/csrBankSim \
    || { echo "Simulation did not pass"; exit 1; }

echo "Simulation passed"
